//--- design/sparse_chunk_config.svh
`ifndef SPARSE_CHUNK_CONFIG_SVH
`define SPARSE_CHUNK_CONFIG_SVH

`default_nettype none

////////////////////////////////////////
// Chunk geometry
////////////////////////////////////////

// Dense positions held by one chunk buffer
`define CHUNK_SIZE 32
// Bitmap bits and byte lanes per write beat
`define BUS_SIZE 8
// Bitmap bits per read segment
`define PREFIX_SUM_SIZE 8

// Derived beat and segment counts
`define WR_DAT_CYC_NUM (`CHUNK_SIZE / `BUS_SIZE)
`define RD_DAT_CYC_NUM (`CHUNK_SIZE / `PREFIX_SUM_SIZE)

`default_nettype wire

`endif

//--- design/sparse_chunk_pkg.sv
`include "sparse_chunk_config.svh"
`default_nettype none

package sparse_chunk_pkg;

	// Dense position and nonzero count widths
	typedef logic [$clog2(`CHUNK_SIZE)-1:0] pos_t;
	typedef logic [$clog2(`CHUNK_SIZE):0] cnt_t;

	// Segment addressing
	typedef logic [$clog2(`RD_DAT_CYC_NUM)-1:0] seg_addr_t;
	typedef logic [$clog2(`PREFIX_SUM_SIZE)-1:0] seg_idx_t;
	typedef logic [`PREFIX_SUM_SIZE-1:0] seg_map_t;

	// One compressed write beat
	typedef struct packed {
		logic valid;
		logic [`BUS_SIZE-1:0] bitmap;
		logic [`BUS_SIZE-1:0][7:0] data;
	} chunk_wr_t;

	// Match event, engine to address calculator
	typedef struct packed {
		logic valid;
		seg_idx_t idx;
		logic seg_end;
		logic chunk_start;
	} match_t;

	// Output event, dense position plus activation
	typedef struct packed {
		logic valid;
		pos_t pos;
		logic [7:0] data;
	} fetch_out_t;

	// Match engine FSM states
	typedef enum logic [1:0] {
		ST_IDLE,
		ST_LOAD,
		ST_STEP,
		ST_DONE
	} match_state_e;

	// Set bit count, callers widen their bitmap first
	function automatic cnt_t popcount(input logic [`CHUNK_SIZE-1:0] bits);
		cnt_t n;
		n = '0;
		for (int i = 0; i < `CHUNK_SIZE; i++) begin
			n = n + cnt_t'(bits[i]);
		end
		return n;
	endfunction

endpackage

`default_nettype wire

//--- design/data_chunk.sv
`include "sparse_chunk_config.svh"
`default_nettype none

module data_chunk
	import sparse_chunk_pkg::*;
(
	input  wire logic  clk_i,
	input  wire logic  reset_i,
	input  chunk_wr_t  wr_i,
	input  wire logic  wr_en_i,
	input  pos_t       rd_addr_i,
	input  seg_addr_t  rd_sparsemap_addr_i,
	output logic [7:0] rd_data_o,
	output seg_map_t   rd_sparsemap_o
);

	localparam int BEAT_W = $clog2(`WR_DAT_CYC_NUM);

	////////////////////////////////////////
	// Storage
	////////////////////////////////////////

	// Full dense bitmap, one BUS_SIZE slice per beat
	logic [`CHUNK_SIZE-1:0] map_q;
	// Compressed nonzero bytes, packed from address 0
	logic [7:0] data_mem [`CHUNK_SIZE];

	// Write beat counter and running byte pointer
	logic [BEAT_W-1:0] beat_q;
	cnt_t wr_ptr_q;
	cnt_t wr_pop;

	// Nonzero lanes carried by this beat
	assign wr_pop = popcount(`CHUNK_SIZE'(wr_i.bitmap));

	////////////////////////////////////////
	// Write side
	////////////////////////////////////////

	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			beat_q   <= '0;
			wr_ptr_q <= '0;
		end
		else if (wr_en_i) begin
			// Last beat closes the chunk
			if (beat_q == BEAT_W'(`WR_DAT_CYC_NUM - 1)) begin
				beat_q   <= '0;
				wr_ptr_q <= '0;
			end
			else begin
				beat_q   <= beat_q + 1'b1;
				wr_ptr_q <= wr_ptr_q + wr_pop;
			end
		end
	end

	always_ff @(posedge clk_i) begin
		if (wr_en_i) begin
			map_q[beat_q*`BUS_SIZE +: `BUS_SIZE] <= wr_i.bitmap;
			// Only the low popcount lanes hold data
			for (int l = 0; l < `BUS_SIZE; l++) begin
				if (cnt_t'(l) < wr_pop) begin
					data_mem[pos_t'(wr_ptr_q + cnt_t'(l))] <= wr_i.data[l];
				end
			end
		end
	end

	////////////////////////////////////////
	// Read side
	////////////////////////////////////////

	// Byte and segment reads are combinational
	assign rd_data_o      = data_mem[rd_addr_i];
	assign rd_sparsemap_o = map_q[rd_sparsemap_addr_i*`PREFIX_SUM_SIZE +: `PREFIX_SUM_SIZE];

endmodule

`default_nettype wire

//--- design/data_addr_cal.sv
`include "sparse_chunk_config.svh"
`default_nettype none

module data_addr_cal
	import sparse_chunk_pkg::*;
(
	input  wire logic clk_i,
	input  wire logic reset_i,
	input  match_t    match_i,
	input  seg_map_t  sparsemap_i,
	output pos_t      rd_dat_addr_o
);

	// Nonzeros in segments already finished
	cnt_t base_q;
	cnt_t base_eff;
	// Segment bits below the match index
	seg_map_t below_mask;
	cnt_t below_cnt;
	cnt_t seg_cnt;
	cnt_t addr_sum;
	pos_t rd_dat_addr_q;

	// First event of a run sees a zero base
	assign base_eff = match_i.chunk_start ? '0 : base_q;

	assign below_mask = (seg_map_t'(1) << match_i.idx) - seg_map_t'(1);
	assign below_cnt  = popcount(`CHUNK_SIZE'(sparsemap_i & below_mask));
	assign seg_cnt    = popcount(`CHUNK_SIZE'(sparsemap_i));
	assign addr_sum   = base_eff + below_cnt;

	////////////////////////////////////////
	// Base accumulation
	////////////////////////////////////////

	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			base_q <= '0;
		end
		else if (match_i.seg_end) begin
			// Whole segment folds into base
			base_q <= base_eff + seg_cnt;
		end
		else if (match_i.chunk_start) begin
			base_q <= '0;
		end
	end

	// Compressed address, one cycle after the match
	always_ff @(posedge clk_i) begin
		if (match_i.valid) begin
			rd_dat_addr_q <= pos_t'(addr_sum);
		end
	end

	assign rd_dat_addr_o = rd_dat_addr_q;

endmodule

`default_nettype wire

//--- design/data_chunk_top.sv
`include "sparse_chunk_config.svh"
`default_nettype none

module data_chunk_top
	import sparse_chunk_pkg::*;
(
	input  wire logic  clk_i,
	input  wire logic  reset_i,
	input  chunk_wr_t  wr_i,
	input  wire logic  wr_sel_i,
	input  wire logic  rd_sel_i,
	input  match_t     match_i,
	input  seg_addr_t  rd_sparsemap_addr_i,
	output seg_map_t   rd_sparsemap_o,
	output fetch_out_t fetch_o
);

	logic [1:0] wr_en_w;
	pos_t rd_dat_addr_w;
	logic [1:0][7:0] rd_dat_w;
	seg_map_t [1:0] rd_sparsemap_w;

	// Match position held to line up with the byte
	logic fetch_vld_q;
	pos_t fetch_pos_q;

	// Write valid goes to the selected buffer only
	assign wr_en_w[0] = wr_i.valid && !wr_sel_i;
	assign wr_en_w[1] = wr_i.valid &&  wr_sel_i;

	// Ping-pong buffer pair
	for (genvar g = 0; g < 2; g++) begin : g_chunk
		data_chunk u_data_chunk (
			.clk_i,
			.reset_i,
			.wr_i,
			.wr_en_i            (wr_en_w[g]),
			.rd_addr_i          (rd_dat_addr_w),
			.rd_sparsemap_addr_i,
			.rd_data_o          (rd_dat_w[g]),
			.rd_sparsemap_o     (rd_sparsemap_w[g])
		);
	end

	// Shared address calculator on the read buffer
	data_addr_cal u_data_addr_cal (
		.clk_i,
		.reset_i,
		.match_i,
		.sparsemap_i   (rd_sparsemap_o),
		.rd_dat_addr_o (rd_dat_addr_w)
	);

	assign rd_sparsemap_o = rd_sparsemap_w[rd_sel_i];

	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			fetch_vld_q <= 1'b0;
		end
		else begin
			fetch_vld_q <= match_i.valid;
		end
	end

	// Dense position is segment then bit index
	always_ff @(posedge clk_i) begin
		if (match_i.valid) begin
			fetch_pos_q <= {rd_sparsemap_addr_i, match_i.idx};
		end
	end

	always_comb begin
		fetch_o.valid = fetch_vld_q;
		fetch_o.pos   = fetch_pos_q;
		fetch_o.data  = rd_dat_w[rd_sel_i];
	end

endmodule

`default_nettype wire

//--- design/match_pri_enc.sv
`include "sparse_chunk_config.svh"
`default_nettype none

module match_pri_enc
	import sparse_chunk_pkg::*;
(
	input  wire logic                   clk_i,
	input  wire logic                   reset_i,
	input  wire logic                   start_i,
	input  wire logic [`CHUNK_SIZE-1:0] filter_map_i,
	input  seg_map_t                    ifm_seg_i,
	output seg_addr_t                   seg_addr_o,
	output match_t                      match_o,
	output logic                        done_o
);

	match_state_e state_q;
	seg_addr_t seg_addr_q;
	// Matches not yet emitted in this segment
	seg_map_t pending_q;
	// Flags the first step cycle of a run
	logic first_q;

	seg_map_t filter_seg;
	seg_idx_t low_idx;

	assign filter_seg = filter_map_i[seg_addr_q*`PREFIX_SUM_SIZE +: `PREFIX_SUM_SIZE];

	// Lowest pending bit wins
	always_comb begin
		low_idx = '0;
		for (int b = `PREFIX_SUM_SIZE - 1; b >= 0; b--) begin
			if (pending_q[b]) begin
				low_idx = seg_idx_t'(b);
			end
		end
	end

	////////////////////////////////////////
	// Segment sequencer
	////////////////////////////////////////

	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			state_q    <= ST_IDLE;
			seg_addr_q <= '0;
			pending_q  <= '0;
			first_q    <= 1'b0;
		end
		else begin
			case (state_q)
				ST_IDLE: begin
					if (start_i) begin
						seg_addr_q <= '0;
						first_q    <= 1'b1;
						state_q    <= ST_LOAD;
					end
				end
				ST_LOAD: begin
					// IFM segment AND filter segment
					pending_q <= ifm_seg_i & filter_seg;
					state_q   <= ST_STEP;
				end
				ST_STEP: begin
					first_q <= 1'b0;
					if (|pending_q) begin
						pending_q <= pending_q & (pending_q - seg_map_t'(1));
					end
					else if (seg_addr_q == seg_addr_t'(`RD_DAT_CYC_NUM - 1)) begin
						state_q <= ST_DONE;
					end
					else begin
						seg_addr_q <= seg_addr_q + 1'b1;
						state_q    <= ST_LOAD;
					end
				end
				default: begin
					state_q <= ST_IDLE;
				end
			endcase
		end
	end

	// Match event, segment end when mask is empty
	always_comb begin
		match_o = '0;
		if (state_q == ST_STEP) begin
			match_o.valid       = |pending_q;
			match_o.idx         = low_idx;
			match_o.seg_end     = ~|pending_q;
			match_o.chunk_start = first_q;
		end
	end

	assign seg_addr_o = seg_addr_q;
	assign done_o     = (state_q == ST_DONE);

endmodule

`default_nettype wire

//--- design/sparse_fetch_top.sv
`include "sparse_chunk_config.svh"
`default_nettype none

module sparse_fetch_top
	import sparse_chunk_pkg::*;
(
	input  wire logic                   clk_i,
	input  wire logic                   reset_i,
	input  chunk_wr_t                   wr_i,
	input  wire logic                   wr_sel_i,
	input  wire logic                   rd_sel_i,
	input  wire logic                   start_i,
	input  wire logic [`CHUNK_SIZE-1:0] filter_map_i,
	output fetch_out_t                  fetch_o,
	output logic                        done_o
);

	////////////////////////////////////////
	// Engine to buffer wiring
	////////////////////////////////////////

	// Segment address out, IFM bitmap back
	seg_addr_t seg_addr_w;
	seg_map_t ifm_seg_w;
	match_t match_w;

	// Chunk buffers and address calculator
	data_chunk_top u_data_chunk_top (
		.clk_i,
		.reset_i,
		.wr_i,
		.wr_sel_i,
		.rd_sel_i,
		.match_i             (match_w),
		.rd_sparsemap_addr_i (seg_addr_w),
		.rd_sparsemap_o      (ifm_seg_w),
		.fetch_o
	);

	// Match stepping
	match_pri_enc u_match_pri_enc (
		.clk_i,
		.reset_i,
		.start_i,
		.filter_map_i,
		.ifm_seg_i  (ifm_seg_w),
		.seg_addr_o (seg_addr_w),
		.match_o    (match_w),
		.done_o
	);

endmodule

`default_nettype wire

//--- sim/sparse_fetch_properties.sv
`default_nettype none

module sparse_fetch_properties (
	input wire logic clk_i,
	input wire logic reset_i,
	input wire logic start_i,
	input wire logic fetch_vld_i,
	input wire logic done_i
);
	timeunit 1ns;
	timeprecision 100ps;

	// Run in flight, start seen and done not yet
	logic busy_q;

	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			busy_q <= 1'b0;
		end
		else if (start_i) begin
			busy_q <= 1'b1;
		end
		else if (done_i) begin
			busy_q <= 1'b0;
		end
	end

	////////////////////////////////////////
	// Handshake rules
	////////////////////////////////////////

	a_done_pulse: assert property (@(posedge clk_i) disable iff (reset_i) done_i |=> !done_i)
		else $error("done_o stayed high for more than one cycle");
	a_fetch_busy: assert property (@(posedge clk_i) disable iff (reset_i) fetch_vld_i |-> busy_q)
		else $error("fetch valid seen while the match engine was idle");
	a_done_busy: assert property (@(posedge clk_i) disable iff (reset_i) done_i |-> busy_q)
		else $error("done_o rose without a run in flight");
	a_start_idle: assert property (@(posedge clk_i) disable iff (reset_i) start_i |-> !busy_q)
		else $error("start_i arrived while a run was still busy");

endmodule

// Attach to every instance of the top level
bind sparse_fetch_top sparse_fetch_properties u_sparse_fetch_properties (
	.clk_i,
	.reset_i,
	.start_i,
	.fetch_vld_i (fetch_o.valid),
	.done_i      (done_o)
);

`default_nettype wire

//--- sim/sparse_fetch_tb.sv
`include "sparse_chunk_config.svh"
`default_nettype none

module sparse_fetch_tb
	import sparse_chunk_pkg::*;
();
	timeunit 1ns;
	timeprecision 100ps;

	localparam int TIMEOUT = 200;

	logic clk;
	logic reset;
	chunk_wr_t wr_beat;
	logic wr_sel;
	logic rd_sel;
	logic start;
	logic [`CHUNK_SIZE-1:0] filter_map;
	fetch_out_t fetch;
	logic done;

	// Dense copy of both buffers, plus the chunk being built
	logic [7:0] model_mem [2][`CHUNK_SIZE];
	logic [7:0] dense_buf [`CHUNK_SIZE];
	// Expected matches of the current run, rising position
	fetch_out_t exp_mem [`CHUNK_SIZE+1];
	fetch_out_t exp_head;
	int exp_cnt = 0;
	int rd_idx = 0;
	int fetch_cnt = 0;
	int err_cnt = 0;
	logic aborted = 1'b0;
	logic [31:0] seed = 32'hd219_d49b;

	sparse_fetch_top UUT (
		.clk_i        (clk),
		.reset_i      (reset),
		.wr_i         (wr_beat),
		.wr_sel_i     (wr_sel),
		.rd_sel_i     (rd_sel),
		.start_i      (start),
		.filter_map_i (filter_map),
		.fetch_o      (fetch),
		.done_o       (done)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	////////////////////////////////////////
	// Output tracking and checks
	////////////////////////////////////////

	// Queue head moves on every returned match
	always @(posedge clk) begin
		if (start) begin
			rd_idx <= 0;
		end
		else if (fetch.valid) begin
			rd_idx    <= rd_idx + 1;
			fetch_cnt <= fetch_cnt + 1;
		end
	end

	assign exp_head = exp_mem[rd_idx];

	a_pos: assert property (@(posedge clk) disable iff (reset)
		fetch.valid |-> fetch.pos == exp_head.pos)
		else begin
			err_cnt++;
			$display("FAILED %0t fetch_o.pos expected %0d actual %0d", $time,
				$sampled(exp_head.pos), $sampled(fetch.pos));
		end
	a_data: assert property (@(posedge clk) disable iff (reset)
		fetch.valid |-> fetch.data == exp_head.data)
		else begin
			err_cnt++;
			$display("FAILED %0t fetch_o.data expected 0x%02h actual 0x%02h", $time,
				$sampled(exp_head.data), $sampled(fetch.data));
		end
	a_extra: assert property (@(posedge clk) disable iff (reset)
		fetch.valid |-> rd_idx < exp_cnt)
		else begin
			err_cnt++;
			$display("%0t: fetch valid beyond the last expected match", $time);
		end
	// Every match is back by the time done_o rises
	a_count: assert property (@(posedge clk) disable iff (reset)
		done |-> rd_idx == exp_cnt)
		else begin
			err_cnt++;
			$display("FAILED %0t match count expected %0d actual %0d", $time,
				$sampled(exp_cnt), $sampled(rd_idx));
		end

	////////////////////////////////////////
	// Stimulus helpers
	////////////////////////////////////////

	function automatic logic [31:0] next_rand();
		seed = seed * 32'd1664525 + 32'd1013904223;
		return seed;
	endfunction

	task automatic fill_random();
		logic [31:0] r;
		for (int p = 0; p < `CHUNK_SIZE; p++) begin
			r = next_rand();
			// Top bit picks zero, so about half the bytes
			dense_buf[p] = r[31] ? 8'h00 : (r[15:8] | 8'h01);
		end
	endtask

	// All zero, or every byte nonzero
	task automatic fill_pattern(input logic zero);
		for (int p = 0; p < `CHUNK_SIZE; p++) begin
			dense_buf[p] = zero ? 8'h00 : (8'ha0 ^ 8'(p));
		end
	endtask

	// Compress dense_buf beat by beat into one buffer
	task automatic write_chunk(input logic sel);
		chunk_wr_t beat;
		int lane;
		int p;
		if (aborted) return;
		for (int b = 0; b < `WR_DAT_CYC_NUM; b++) begin
			beat = '0;
			beat.valid = 1'b1;
			lane = 0;
			for (int l = 0; l < `BUS_SIZE; l++) begin
				p = b * `BUS_SIZE + l;
				model_mem[sel][p] = dense_buf[p];
				if (dense_buf[p] != 8'h00) begin
					beat.bitmap[l]    = 1'b1;
					beat.data[lane] = dense_buf[p];
					lane++;
				end
			end
			@(posedge clk);
			wr_beat <= beat;
			wr_sel  <= sel;
		end
		@(posedge clk);
		wr_beat <= '0;
	endtask

	// Build the expected list, start a run, wait for done_o
	task automatic run_check(input logic sel, input logic [`CHUNK_SIZE-1:0] filt);
		int cyc;
		if (aborted) return;
		@(posedge clk);
		exp_cnt = 0;
		for (int p = 0; p < `CHUNK_SIZE; p++) begin
			if (model_mem[sel][p] != 8'h00 && filt[p]) begin
				exp_mem[exp_cnt].valid = 1'b1;
				exp_mem[exp_cnt].pos   = pos_t'(p);
				exp_mem[exp_cnt].data  = model_mem[sel][p];
				exp_cnt++;
			end
		end
		rd_sel     <= sel;
		filter_map <= filt;
		start      <= 1'b1;
		@(posedge clk);
		start <= 1'b0;
		cyc = 0;
		while (!done && cyc < TIMEOUT) begin
			@(negedge clk);
			cyc++;
		end
		if (!done) begin
			err_cnt++;
			aborted = 1'b1;
			$display("%0t: done_o did not rise within %0d cycles", $time, TIMEOUT);
		end
	endtask

	////////////////////////////////////////
	// Test sequence
	////////////////////////////////////////

	initial begin
		logic [`CHUNK_SIZE-1:0] filt;
		reset      = 1'b1;
		wr_beat    = '0;
		wr_sel     = 1'b0;
		rd_sel     = 1'b0;
		start      = 1'b0;
		filter_map = '0;
		repeat (2) @(posedge clk);
		reset <= 1'b0;
		repeat (3) @(posedge clk);

		// Random chunks, write order swaps each round
		for (int n = 0; n < 6; n++) begin
			fill_random();
			write_chunk(n[0]);
			fill_random();
			write_chunk(!n[0]);
			run_check(1'b0, next_rand());
			run_check(1'b1, next_rand());
		end

		// Same buffer and filter twice in a row
		filt = next_rand();
		run_check(1'b1, filt);
		run_check(1'b1, filt);

		// Empty filter, then empty chunk
		run_check(1'b0, '0);
		fill_pattern(1'b1);
		write_chunk(1'b0);
		run_check(1'b0, '1);

		// Dense chunk, base carried over all segments
		fill_pattern(1'b0);
		write_chunk(1'b1);
		run_check(1'b1, '1);
		run_check(1'b1, '1);

		repeat (2) @(posedge clk);
		$display("Closing: %0d errors, %0d fetches checked", err_cnt, fetch_cnt);
		if (err_cnt == 0) begin
			$display("Simulation finished: PASS");
		end
		else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- files.f
+incdir+design
design/sparse_chunk_pkg.sv
design/data_chunk.sv
design/data_addr_cal.sv
design/data_chunk_top.sv
design/match_pri_enc.sv
design/sparse_fetch_top.sv
sim/sparse_fetch_properties.sv
sim/sparse_fetch_tb.sv

//--- run.sh
#!/bin/sh
set -e

# Build the testbench and RTL into one binary
verilator --binary --timing --assert -Wno-fatal -f files.f \
	--top-module sparse_fetch_tb -o sim_sparse_fetch

# A crash or a stopped assertion fails the run
./obj_dir/sim_sparse_fetch > sim.log 2>&1 || { cat sim.log; exit 1; }
cat sim.log

if grep -q "Simulation finished: FAIL" sim.log; then
	exit 1
fi
grep -q "Simulation finished: PASS" sim.log
